// File: hw/ooo_types_pkg.sv
// Out-of-order core shared types
`default_nettype none

package ooo_types_pkg;

    // ==============================
    // Basic fields
    // ==============================
    // 128 physical registers
    typedef logic [6:0] tag_t;
    typedef logic [4:0] rob_idx_t;
    typedef logic [4:0] alu_func_t;
    // Raw unit code, decoded through fu_pkg::fu_type_e
    typedef logic [1:0] fu_code_t;

    // ==============================
    // Renamed instruction into dispatch
    // ==============================
    typedef struct packed {
        fu_code_t  fu_type;
        alu_func_t alu_func;
        tag_t      src1_tag;
        tag_t      src2_tag;
        tag_t      dest_tag;
        rob_idx_t  rob_idx;
        logic      has_dest;
    } disp_inst_t;

    // Slot contents
    typedef struct packed {
        disp_inst_t inst;
        logic       src1_ready;
        logic       src2_ready;
        // Dispatched behind an unresolved branch
        logic       spec;
        logic       valid;
    } rs_entry_t;

    // Single result broadcast
    typedef struct packed {
        logic valid;
        tag_t tag;
    } cdb_t;

endpackage

`default_nettype wire

// File: hw/fu_pkg.sv
// Functional unit types and issue packet
`default_nettype none

package fu_pkg;

    // One issue port per unit type
    typedef enum ooo_types_pkg::fu_code_t {
        FU_ALU    = 2'd0,
        FU_MUL    = 2'd1,
        FU_MEM    = 2'd2,
        FU_BRANCH = 2'd3
    } fu_type_e;

    localparam int unsigned FU_TYPES = 4;

    // Issued instruction, a single-cycle valid pulse
    typedef struct packed {
        logic                      valid;
        ooo_types_pkg::alu_func_t  alu_func;
        ooo_types_pkg::tag_t       src1_tag;
        ooo_types_pkg::tag_t       src2_tag;
        ooo_types_pkg::tag_t       dest_tag;
        ooo_types_pkg::rob_idx_t   rob_idx;
    } issue_pkt_t;

endpackage

`default_nettype wire

// File: hw/dispatch_stage.sv
// Dispatch with ready scoreboard
`default_nettype none

module dispatch_stage #(
    parameter int unsigned PHYS_REGS = 128
) (
    input  logic                      clock,
    input  logic                      reset,
    // Renamed instruction from the front end
    input  logic                      disp_valid_i,
    input  ooo_types_pkg::disp_inst_t disp_inst_i,
    // Result broadcast
    input  ooo_types_pkg::cdb_t       cdb_i,
    input  logic                      br_resolve_i,
    // Buffer side
    input  logic                      rs_full_i,
    output logic                      dispatch_stall_o,
    output logic                      alloc_valid_o,
    output ooo_types_pkg::rs_entry_t  alloc_entry_o
);

    import ooo_types_pkg::*;
    import fu_pkg::*;

    // One bit per physical register, set means value available
    logic [PHYS_REGS-1:0] ready_sb;
    // Single speculation level
    logic                 spec_q;
    logic                 accept;
    logic                 src1_hit;
    logic                 src2_hit;
    rs_entry_t            entry;

    // Handshake
    assign accept           = disp_valid_i && !rs_full_i;
    assign dispatch_stall_o = rs_full_i;

    // Same-cycle broadcast counts as ready
    assign src1_hit = cdb_i.valid && (cdb_i.tag == disp_inst_i.src1_tag);
    assign src2_hit = cdb_i.valid && (cdb_i.tag == disp_inst_i.src2_tag);

    // ==============================
    // Build the slot entry
    // ==============================
    always_comb begin
        entry            = '0;
        entry.inst       = disp_inst_i;
        entry.src1_ready = ready_sb[disp_inst_i.src1_tag] || src1_hit;
        entry.src2_ready = ready_sb[disp_inst_i.src2_tag] || src2_hit;
        // Mark taken from the level before this instruction
        entry.spec       = spec_q;
        entry.valid      = 1'b1;
    end

    assign alloc_valid_o = accept;
    assign alloc_entry_o = entry;

    // ==============================
    // Scoreboard
    // ==============================
    always_ff @(posedge clock) begin
        if (reset) begin
            ready_sb <= '1;
        end else begin
            if (cdb_i.valid) begin
                ready_sb[cdb_i.tag] <= 1'b1;
            end
            // New producer wins over a broadcast of the same tag
            if (accept && disp_inst_i.has_dest) begin
                ready_sb[disp_inst_i.dest_tag] <= 1'b0;
            end
        end
    end

    // Speculation level
    // A dispatched branch opens it, any resolve closes it
    always_ff @(posedge clock) begin
        if (reset) begin
            spec_q <= 1'b0;
        end else if (accept && (disp_inst_i.fu_type == FU_BRANCH)) begin
            spec_q <= 1'b1;
        end else if (br_resolve_i) begin
            spec_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hw/rs_slot.sv
// Reservation station slot
`default_nettype none

module rs_slot (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     write_i,
    input  ooo_types_pkg::rs_entry_t entry_i,
    input  ooo_types_pkg::cdb_t      cdb_i,
    input  logic                     grant_i,
    input  logic                     br_resolve_i,
    input  logic                     br_mispredict_i,
    output ooo_types_pkg::rs_entry_t entry_o,
    output logic                     ready_o
);

    import ooo_types_pkg::*;

    rs_entry_t entry_q;
    rs_entry_t entry_d;
    logic      squash;
    logic      commit;

    // Mispredict only counts alongside a resolve
    assign squash = br_resolve_i && br_mispredict_i;
    assign commit = br_resolve_i && !br_mispredict_i;

    // ==============================
    // Next state
    // ==============================
    always_comb begin
        entry_d = entry_q;
        if (write_i) begin
            // Incoming ready bits already include this cycle's CDB
            entry_d = entry_i;
        end else begin
            // Tag wakeup of waiting sources only
            if (cdb_i.valid && !entry_q.src1_ready &&
                (cdb_i.tag == entry_q.inst.src1_tag)) begin
                entry_d.src1_ready = 1'b1;
            end
            if (cdb_i.valid && !entry_q.src2_ready &&
                (cdb_i.tag == entry_q.inst.src2_tag)) begin
                entry_d.src2_ready = 1'b1;
            end
            if (grant_i) begin
                entry_d.valid = 1'b0;
            end
        end
        // Branch outcome applies to a same-cycle write too
        if (squash && entry_d.spec) begin
            entry_d.valid = 1'b0;
        end
        if (commit) begin
            entry_d.spec = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_q.valid <= 1'b0;
            entry_q.spec  <= 1'b0;
        end else begin
            entry_q <= entry_d;
        end
    end

    assign entry_o = entry_q;
    assign ready_o = entry_q.valid && entry_q.src1_ready && entry_q.src2_ready;

endmodule

`default_nettype wire

// File: hw/rs_alloc_select.sv
// Free slot allocator
`default_nettype none

module rs_alloc_select #(
    parameter int unsigned RS_DEPTH = 8
) (
    // Occupied slots
    input  logic [RS_DEPTH-1:0] valid_vec_i,
    input  logic                write_i,
    // One-hot target slot
    output logic [RS_DEPTH-1:0] write_vec_o,
    output logic                full_o
);

    logic [RS_DEPTH-1:0] free_vec;
    logic [RS_DEPTH-1:0] first_free;

    assign free_vec = ~valid_vec_i;

    // Isolate the lowest set bit
    // Two's complement trick, zero when nothing is free
    assign first_free = free_vec & (~free_vec + 1'b1);

    // ==============================
    // Outputs
    // ==============================
    // Nothing routed unless dispatch asks
    assign write_vec_o = write_i ? first_free : '0;

    // Full when every slot holds an entry
    assign full_o = ~|free_vec;

endmodule

`default_nettype wire

// File: hw/reservation_station.sv
// Reservation station buffer
`default_nettype none

module reservation_station #(
    parameter int unsigned RS_DEPTH = 8
) (
    input  logic                                    clock,
    input  logic                                    reset,
    // From dispatch
    input  logic                                    alloc_valid_i,
    input  ooo_types_pkg::rs_entry_t                alloc_entry_i,
    // Broadcast and branch outcome
    input  ooo_types_pkg::cdb_t                     cdb_i,
    input  logic                                    br_resolve_i,
    input  logic                                    br_mispredict_i,
    // From issue select
    input  logic [RS_DEPTH-1:0]                     issue_grant_i,
    output logic                                    rs_full_o,
    // Slot view for issue select
    output ooo_types_pkg::rs_entry_t [RS_DEPTH-1:0] slot_entries_o,
    output logic [RS_DEPTH-1:0]                     slot_ready_o
);

    // Occupancy and write routing
    logic [RS_DEPTH-1:0] slot_valid;
    logic [RS_DEPTH-1:0] slot_write;

    // ==============================
    // Occupancy
    // ==============================
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            slot_valid[i] = slot_entries_o[i].valid;
        end
    end

    // Lowest empty slot takes the new entry
    rs_alloc_select #(
        .RS_DEPTH(RS_DEPTH)
    ) alloc_sel_i (
        .valid_vec_i(slot_valid),
        .write_i    (alloc_valid_i),
        .write_vec_o(slot_write),
        .full_o     (rs_full_o)
    );

    // ==============================
    // Slot array
    // ==============================
    // Every slot sees the same entry, CDB and branch lines
    // Only the write vector decides who captures
    for (genvar g = 0; g < RS_DEPTH; g++) begin : g_slot
        rs_slot slot_i (
            .clock          (clock),
            .reset          (reset),
            .write_i        (slot_write[g]),
            .entry_i        (alloc_entry_i),
            .cdb_i          (cdb_i),
            .grant_i        (issue_grant_i[g]),
            .br_resolve_i   (br_resolve_i),
            .br_mispredict_i(br_mispredict_i),
            .entry_o        (slot_entries_o[g]),
            .ready_o        (slot_ready_o[g])
        );
    end

endmodule

`default_nettype wire

// File: hw/issue_select.sv
// Issue select per unit type
`default_nettype none

module issue_select #(
    parameter int unsigned RS_DEPTH = 8
) (
    input  logic                                     clock,
    input  logic                                     reset,
    input  ooo_types_pkg::rs_entry_t [RS_DEPTH-1:0]  slot_entries_i,
    input  logic [RS_DEPTH-1:0]                      slot_ready_i,
    // One bit per type at most
    output logic [RS_DEPTH-1:0]                      issue_grant_o,
    output fu_pkg::issue_pkt_t [fu_pkg::FU_TYPES-1:0] issue_o
);

    import fu_pkg::*;

    logic [RS_DEPTH-1:0]         grant;
    issue_pkt_t [FU_TYPES-1:0]   pkt_d;
    issue_pkt_t [FU_TYPES-1:0]   pkt_q;

    // ==============================
    // Select
    // ==============================
    // Lowest ready slot of each type wins
    always_comb begin
        grant = '0;
        pkt_d = '0;
        for (int t = 0; t < FU_TYPES; t++) begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (!pkt_d[t].valid && slot_ready_i[i] &&
                    (slot_entries_i[i].inst.fu_type == fu_type_e'(t))) begin
                    grant[i]          = 1'b1;
                    pkt_d[t].valid    = 1'b1;
                    pkt_d[t].alu_func = slot_entries_i[i].inst.alu_func;
                    pkt_d[t].src1_tag = slot_entries_i[i].inst.src1_tag;
                    pkt_d[t].src2_tag = slot_entries_i[i].inst.src2_tag;
                    pkt_d[t].dest_tag = slot_entries_i[i].inst.dest_tag;
                    pkt_d[t].rob_idx  = slot_entries_i[i].inst.rob_idx;
                end
            end
        end
    end

    // Granted slot empties at the same edge
    assign issue_grant_o = grant;

    // ==============================
    // Issue register
    // ==============================
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int t = 0; t < FU_TYPES; t++) begin
                pkt_q[t].valid <= 1'b0;
            end
        end else begin
            pkt_q <= pkt_d;
        end
    end

    assign issue_o = pkt_q;

endmodule

`default_nettype wire

// File: hw/ooo_issue_top.sv
// Wait-and-issue stage top
`default_nettype none

module ooo_issue_top #(
    parameter int unsigned RS_DEPTH  = 8,
    parameter int unsigned PHYS_REGS = 128
) (
    input  logic                                      clock,
    input  logic                                      reset,
    // Dispatch
    input  logic                                      disp_valid_i,
    input  ooo_types_pkg::disp_inst_t                 disp_inst_i,
    output logic                                      dispatch_stall_o,
    // Results and branch outcome
    input  ooo_types_pkg::cdb_t                       cdb_i,
    input  logic                                      br_resolve_i,
    input  logic                                      br_mispredict_i,
    // One packet per unit type
    output fu_pkg::issue_pkt_t [fu_pkg::FU_TYPES-1:0] issue_o
);

    import ooo_types_pkg::*;

    logic                       alloc_valid;
    rs_entry_t                  alloc_entry;
    logic                       rs_full;
    rs_entry_t [RS_DEPTH-1:0]   slot_entries;
    logic [RS_DEPTH-1:0]        slot_ready;
    logic [RS_DEPTH-1:0]        issue_grant;

    // ==============================
    // Producer, buffer, consumer
    // ==============================
    dispatch_stage #(
        .PHYS_REGS(PHYS_REGS)
    ) dispatch_i (
        .clock           (clock),
        .reset           (reset),
        .disp_valid_i    (disp_valid_i),
        .disp_inst_i     (disp_inst_i),
        .cdb_i           (cdb_i),
        .br_resolve_i    (br_resolve_i),
        .rs_full_i       (rs_full),
        .dispatch_stall_o(dispatch_stall_o),
        .alloc_valid_o   (alloc_valid),
        .alloc_entry_o   (alloc_entry)
    );

    reservation_station #(
        .RS_DEPTH(RS_DEPTH)
    ) rs_i (
        .clock          (clock),
        .reset          (reset),
        .alloc_valid_i  (alloc_valid),
        .alloc_entry_i  (alloc_entry),
        .cdb_i          (cdb_i),
        .br_resolve_i   (br_resolve_i),
        .br_mispredict_i(br_mispredict_i),
        .issue_grant_i  (issue_grant),
        .rs_full_o      (rs_full),
        .slot_entries_o (slot_entries),
        .slot_ready_o   (slot_ready)
    );

    issue_select #(
        .RS_DEPTH(RS_DEPTH)
    ) issue_sel_i (
        .clock         (clock),
        .reset         (reset),
        .slot_entries_i(slot_entries),
        .slot_ready_i  (slot_ready),
        .issue_grant_o (issue_grant),
        .issue_o       (issue_o)
    );

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
// Testbench clock and reset
`default_nettype none

module tb_clock_gen #(
    parameter int unsigned PERIOD_NS    = 40,
    parameter int unsigned RESET_CYCLES = 16
) (
    output logic clock_o,
    output logic reset_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // Free-running clock
    initial begin
        clock_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clock_o = ~clock_o;
        end
    end

    // Synchronous reset, released just after a rising edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock_o);
        reset_o <= 1'b0;
    end

endmodule

`default_nettype wire

// File: verif/ooo_issue_tb.sv
// Issue stage directed testbench
`default_nettype none

module ooo_issue_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import ooo_types_pkg::*;
    import fu_pkg::*;

    localparam int unsigned RS_DEPTH  = 8;
    localparam int unsigned PHYS_REGS = 128;
    // Reset, six tests, then margin
    localparam int unsigned BUDGET = 16 + 20 + 40 + 40 + 100 + 80 + 80 + 100;

    logic                      clock;
    logic                      reset;
    logic                      disp_valid;
    disp_inst_t                disp_inst;
    logic                      dispatch_stall;
    cdb_t                      cdb;
    logic                      br_resolve;
    logic                      br_mispredict;
    issue_pkt_t [FU_TYPES-1:0] issue;

    logic [31:0]  lcg_state = 32'hffd3;
    int unsigned  errors    = 0;
    int unsigned  tests_run = 0;
    int unsigned  tests_bad = 0;
    // Every packet seen on issue_o
    issue_pkt_t   issued_q[$];

    tb_clock_gen #(
        .PERIOD_NS   (40),
        .RESET_CYCLES(16)
    ) clock_gen_i (
        .clock_o(clock),
        .reset_o(reset)
    );

    ooo_issue_top #(
        .RS_DEPTH (RS_DEPTH),
        .PHYS_REGS(PHYS_REGS)
    ) ooo_issue_top_i (
        .clock           (clock),
        .reset           (reset),
        .disp_valid_i    (disp_valid),
        .disp_inst_i     (disp_inst),
        .dispatch_stall_o(dispatch_stall),
        .cdb_i           (cdb),
        .br_resolve_i    (br_resolve),
        .br_mispredict_i (br_mispredict),
        .issue_o         (issue)
    );

    // ==============================
    // Stimulus helpers
    // ==============================
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Lower half of the tag space is never a destination, so always ready
    function automatic tag_t ready_tag();
        logic [31:0] r;
        r = next_rand();
        return {1'b0, r[22:17]};
    endfunction

    function automatic disp_inst_t make_inst(input fu_type_e fu, input tag_t src1,
                                             input logic has_dest);
        disp_inst_t  inst;
        logic [31:0] r;
        r = next_rand();
        inst.fu_type  = fu;
        inst.alu_func = r[20:16];
        inst.rob_idx  = r[28:24];
        inst.src1_tag = src1;
        inst.src2_tag = ready_tag();
        r = next_rand();
        // Destinations live in the upper half
        inst.dest_tag = {1'b1, r[22:17]};
        inst.has_dest = has_dest;
        return inst;
    endfunction

    // Issued packet carries the driven fields unchanged
    function automatic issue_pkt_t expected_pkt(input disp_inst_t inst);
        issue_pkt_t pkt;
        pkt.valid    = 1'b1;
        pkt.alu_func = inst.alu_func;
        pkt.src1_tag = inst.src1_tag;
        pkt.src2_tag = inst.src2_tag;
        pkt.dest_tag = inst.dest_tag;
        pkt.rob_idx  = inst.rob_idx;
        return pkt;
    endfunction

    // Returns just after the accepting edge
    task automatic dispatch(input disp_inst_t inst);
        @(posedge clock);
        disp_valid <= 1'b1;
        disp_inst  <= inst;
        @(negedge clock);
        while (dispatch_stall) begin
            @(negedge clock);
        end
        @(posedge clock);
        disp_valid <= 1'b0;
    endtask

    // Returns just after the edge that samples the broadcast
    task automatic broadcast(input tag_t tag);
        @(posedge clock);
        cdb.valid <= 1'b1;
        cdb.tag   <= tag;
        @(posedge clock);
        cdb <= '0;
    endtask

    task automatic pulse_resolve(input logic mispredict);
        @(posedge clock);
        br_resolve    <= 1'b1;
        br_mispredict <= mispredict;
        @(posedge clock);
        br_resolve    <= 1'b0;
        br_mispredict <= 1'b0;
    endtask

    // Log issues where the outputs are stable
    always @(negedge clock) begin
        if (!reset) begin
            for (int t = 0; t < FU_TYPES; t++) begin
                if (issue[t].valid === 1'b1) begin
                    issued_q.push_back(issue[t]);
                end
            end
        end
    end

    // ==============================
    // Checks
    // ==============================
    task automatic check_pkt(input string what, input issue_pkt_t got, input issue_pkt_t exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input issue_pkt_t exp,
                               input int unsigned times);
        int unsigned seen;
        seen = 0;
        foreach (issued_q[i]) begin
            if (issued_q[i] === exp) begin
                seen++;
            end
        end
        if (seen != times) begin
            errors++;
            $display("%s was issued %0d times instead of %0d", what, seen, times);
        end
    endtask

    task automatic wait_issued(input int unsigned count, input int unsigned max_cycles);
        int unsigned n;
        n = 0;
        while ((issued_q.size() < count) && (n < max_cycles)) begin
            @(posedge clock);
            n++;
        end
        if (issued_q.size() < count) begin
            errors++;
            $display("Timeout: only %0d of %0d instructions issued within %0d cycles",
                     issued_q.size(), count, max_cycles);
        end
    endtask

    task automatic check_total(input int unsigned count);
        if (issued_q.size() != count) begin
            errors++;
            $display("Issue count wrong: %0d packets seen, %0d expected",
                     issued_q.size(), count);
        end
    endtask

    task automatic end_test(input string name, input int unsigned errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    // ==============================
    // Tests
    // ==============================
    task automatic test_reset();
        int unsigned err0;
        err0 = errors;
        repeat (10) begin
            @(negedge clock);
            check_level("stall after reset", dispatch_stall, 1'b0);
            for (int t = 0; t < FU_TYPES; t++) begin
                check_level("issue valid after reset", issue[t].valid, 1'b0);
            end
        end
        end_test("reset", err0);
    endtask

    // Ready at dispatch, out two edges after acceptance, one cycle wide
    task automatic test_ready();
        int unsigned err0;
        disp_inst_t  inst;
        err0 = errors;
        for (int t = 0; t < FU_TYPES; t++) begin
            inst = make_inst(fu_type_e'(t), ready_tag(), 1'b1);
            dispatch(inst);
            @(negedge clock);
            check_level("issue valid one edge after accept", issue[t].valid, 1'b0);
            @(negedge clock);
            check_pkt("ready issue", issue[t], expected_pkt(inst));
            @(negedge clock);
            check_level("issue valid after pulse", issue[t].valid, 1'b0);
        end
        // Close the level opened by the branch
        pulse_resolve(1'b0);
        end_test("ready instruction", err0);
    endtask

    task automatic test_wakeup();
        int unsigned err0;
        disp_inst_t  producer;
        disp_inst_t  waiter;
        err0 = errors;
        issued_q.delete();
        producer = make_inst(FU_ALU, ready_tag(), 1'b1);
        waiter   = make_inst(FU_MUL, producer.dest_tag, 1'b1);
        dispatch(producer);
        dispatch(waiter);
        repeat (8) begin
            @(negedge clock);
            check_level("waiting instruction issued early", issue[FU_MUL].valid, 1'b0);
        end
        broadcast(producer.dest_tag);
        @(negedge clock);
        check_level("issue valid at wakeup edge", issue[FU_MUL].valid, 1'b0);
        @(negedge clock);
        check_pkt("woken issue", issue[FU_MUL], expected_pkt(waiter));
        @(posedge clock);
        check_count("producer", expected_pkt(producer), 1);
        check_count("woken instruction", expected_pkt(waiter), 1);
        end_test("wakeup", err0);
    endtask

    task automatic test_full_drain();
        int unsigned err0;
        disp_inst_t  producer;
        disp_inst_t  extra;
        disp_inst_t  waiters[RS_DEPTH];
        err0 = errors;
        issued_q.delete();
        producer = make_inst(FU_ALU, ready_tag(), 1'b1);
        dispatch(producer);
        for (int i = 0; i < RS_DEPTH; i++) begin
            waiters[i] = make_inst(fu_type_e'(i % FU_TYPES), producer.dest_tag, 1'b1);
            dispatch(waiters[i]);
        end
        @(negedge clock);
        check_level("stall with buffer full", dispatch_stall, 1'b1);
        extra = make_inst(FU_ALU, producer.dest_tag, 1'b1);
        fork
            dispatch(extra);
            begin
                repeat (4) begin
                    @(negedge clock);
                    check_level("stall while held", dispatch_stall, 1'b1);
                end
                broadcast(producer.dest_tag);
            end
        join
        wait_issued(RS_DEPTH + 2, 40);
        repeat (6) @(posedge clock);
        check_count("producer", expected_pkt(producer), 1);
        for (int i = 0; i < RS_DEPTH; i++) begin
            check_count($sformatf("waiter %0d", i), expected_pkt(waiters[i]), 1);
        end
        check_count("held instruction", expected_pkt(extra), 1);
        check_total(RS_DEPTH + 2);
        pulse_resolve(1'b0);
        end_test("full and drain", err0);
    endtask

    // Older waiter, branch, two younger waiters, then the outcome
    task automatic test_branch(input logic mispredict);
        int unsigned err0;
        int unsigned young_times;
        disp_inst_t  producer;
        disp_inst_t  older;
        disp_inst_t  branch;
        disp_inst_t  young_a;
        disp_inst_t  young_b;
        err0 = errors;
        issued_q.delete();
        producer = make_inst(FU_ALU, ready_tag(), 1'b1);
        older    = make_inst(FU_MEM, producer.dest_tag, 1'b1);
        branch   = make_inst(FU_BRANCH, ready_tag(), 1'b0);
        young_a  = make_inst(FU_ALU, producer.dest_tag, 1'b1);
        young_b  = make_inst(FU_MUL, producer.dest_tag, 1'b1);
        dispatch(producer);
        dispatch(older);
        dispatch(branch);
        dispatch(young_a);
        dispatch(young_b);
        pulse_resolve(mispredict);
        repeat (2) @(posedge clock);
        broadcast(producer.dest_tag);
        // Squashed ones must stay silent
        young_times = mispredict ? 0 : 1;
        wait_issued(mispredict ? 3 : 5, 20);
        repeat (10) @(posedge clock);
        check_count("producer", expected_pkt(producer), 1);
        check_count("older instruction", expected_pkt(older), 1);
        check_count("branch", expected_pkt(branch), 1);
        check_count("younger ALU", expected_pkt(young_a), young_times);
        check_count("younger MUL", expected_pkt(young_b), young_times);
        check_total(mispredict ? 3 : 5);
        end_test(mispredict ? "mispredict" : "correct resolve", err0);
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        disp_valid    = 1'b0;
        disp_inst     = '0;
        cdb           = '0;
        br_resolve    = 1'b0;
        br_mispredict = 1'b0;
        @(posedge clock);
        while (reset) begin
            @(posedge clock);
        end
        test_reset();
        test_ready();
        test_wakeup();
        test_full_drain();
        test_branch(1'b1);
        test_branch(1'b0);
        $display("Tests run %0d, tests with errors %0d, total errors %0d",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (BUDGET) @(posedge clock);
        $display("Watchdog expired after %0d cycles, run did not complete", BUDGET);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
hw/ooo_types_pkg.sv
hw/fu_pkg.sv
hw/dispatch_stage.sv
hw/rs_slot.sv
hw/rs_alloc_select.sv
hw/reservation_station.sv
hw/issue_select.sv
hw/ooo_issue_top.sv
verif/tb_clock_gen.sv
verif/ooo_issue_tb.sv

// File: Bender.yml
package:
  name: ooo_issue

sources:
  - hw/ooo_types_pkg.sv
  - hw/fu_pkg.sv
  - hw/dispatch_stage.sv
  - hw/rs_slot.sv
  - hw/rs_alloc_select.sv
  - hw/reservation_station.sv
  - hw/issue_select.sv
  - hw/ooo_issue_top.sv

  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/ooo_issue_tb.sv
